//--- common/db_pkg.sv
package db_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    localparam int KEY_WID       = 16;
    localparam int VALUE_WID     = 24;
    localparam int FILL_WID      = 8;
    localparam int AXIL_ADDR_WID = 8;
    localparam int AXIL_DATA_WID = 32;
    localparam int AXIL_RESP_WID = 2;

    // ----------------------------------------------------------------------
    // Data types
    // ----------------------------------------------------------------------
    typedef logic [KEY_WID-1:0]       key_t;
    typedef logic [VALUE_WID-1:0]     value_t;
    typedef logic [FILL_WID-1:0]      fill_t;
    typedef logic [AXIL_ADDR_WID-1:0] axil_addr_t;
    typedef logic [AXIL_DATA_WID-1:0] axil_data_t;
    typedef logic [AXIL_RESP_WID-1:0] axil_resp_t;

    // One stash entry, key in the upper bits
    typedef struct packed {
        key_t   key;
        value_t value;
    } db_entry_t;

    // Full at bit 9, empty at bit 8, fill below
    typedef struct packed {
        logic  full;
        logic  empty;
        fill_t fill;
    } db_status_t;

    // AXI4-Lite responses
    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // ----------------------------------------------------------------------
    // Register map
    // ----------------------------------------------------------------------
    localparam axil_addr_t REG_KEY    = 8'h00;
    localparam axil_addr_t REG_INSERT = 8'h04;
    localparam axil_addr_t REG_LOOKUP = 8'h08;
    localparam axil_addr_t REG_STATUS = 8'h0C;

endpackage : db_pkg

//--- db_stash/db_stash_fifo.sv
`timescale 1ns/10ps

module db_stash_fifo
    import db_pkg::*;
#(
    parameter int SIZE = 8
) (
    input  logic       clk,
    input  logic       __srst,
    output logic       init_done,

    // Insert port from the front end
    input  logic       ins_req,
    input  db_entry_t  ins_entry,
    output logic       ins_ack,
    output logic       ins_err,

    // Pop port from the evictor
    input  logic       pop_req,
    output logic       pop_ack,
    output db_entry_t  pop_entry,

    // Key search
    input  key_t       lookup_key,
    output logic       lookup_hit,
    output value_t     lookup_value,

    output db_status_t status
);

    // ----------------------------------------------------------------------
    // Local types and signals
    // ----------------------------------------------------------------------
    localparam int IDX_WID = (SIZE > 1) ? $clog2(SIZE) : 1;

    typedef logic [IDX_WID-1:0] idx_t;

    db_entry_t       stash [SIZE];
    logic [SIZE-1:0] vld;
    fill_t           count;

    logic full;
    logic empty;
    logic ins_fire;
    logic pop_fire;
    idx_t rd_ptr;

    logic hit;
    idx_t hit_idx;

    // ----------------------------------------------------------------------
    // Init done
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (__srst) begin
            init_done <= 1'b0;
        end else begin
            init_done <= 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Request qualification
    // ----------------------------------------------------------------------
    // Insert wins over pop; a full stash drops the insert
    assign ins_fire = ins_req && !full;

    // A request still high in its ack cycle is the same pop, not a new one
    assign pop_fire = pop_req && !ins_req && !pop_ack && !empty;

    // Oldest entry sits just below the fill level
    assign rd_ptr = empty ? '0 : idx_t'(count - fill_t'(1));

    // ----------------------------------------------------------------------
    // Fill count and valid vector
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (__srst) begin
            count <= '0;
        end else if (ins_fire) begin
            count <= count + fill_t'(1);
        end else if (pop_fire) begin
            count <= count - fill_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (__srst) begin
            vld <= '0;
        end else if (ins_fire) begin
            for (int i = SIZE-1; i > 0; i--) begin
                vld[i] <= vld[i-1];
            end
            vld[0] <= 1'b1;
        end else if (pop_fire) begin
            vld[rd_ptr] <= 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    // Entry storage
    // ----------------------------------------------------------------------
    // Newest at index 0, everything moves up on insert
    always_ff @(posedge clk) begin
        if (ins_fire) begin
            for (int i = SIZE-1; i > 0; i--) begin
                stash[i] <= stash[i-1];
            end
            stash[0] <= ins_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_fire) begin
            pop_entry <= stash[rd_ptr];
        end
    end

    // ----------------------------------------------------------------------
    // Acknowledges
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (__srst) begin
            ins_ack <= 1'b0;
            pop_ack <= 1'b0;
        end else begin
            ins_ack <= ins_req;
            pop_ack <= pop_fire;
        end
    end

    // Error flag only has meaning alongside ins_ack
    always_ff @(posedge clk) begin
        if (ins_req) begin
            ins_err <= full;
        end
    end

    // ----------------------------------------------------------------------
    // Parallel search
    // ----------------------------------------------------------------------
    // Scan from the top so the lowest matching index is left standing
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = SIZE-1; i >= 0; i--) begin
            if (vld[i] && (stash[i].key == lookup_key)) begin
                hit     = 1'b1;
                hit_idx = idx_t'(i);
            end
        end
    end

    assign lookup_hit   = hit;
    assign lookup_value = hit ? stash[hit_idx].value : '0;

    // ----------------------------------------------------------------------
    // Status
    // ----------------------------------------------------------------------
    assign full  = (count == fill_t'(SIZE));
    assign empty = (count == '0);

    assign status = '{full: full, empty: empty, fill: count};

endmodule : db_stash_fifo

//--- rtl/db_axil_front.sv
`timescale 1ns/10ps

module db_axil_front
    import db_pkg::*;
(
    input  logic       clk,
    input  logic       __srst,
    input  logic       init_done,

    // AXI4-Lite write channels
    input  logic       awvalid,
    output logic       awready,
    input  axil_addr_t awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  axil_data_t wdata,
    output logic       bvalid,
    input  logic       bready,
    output axil_resp_t bresp,

    // AXI4-Lite read channels
    input  logic       arvalid,
    output logic       arready,
    input  axil_addr_t araddr,
    output logic       rvalid,
    input  logic       rready,
    output axil_data_t rdata,
    output axil_resp_t rresp,

    // Stash side
    output logic       ins_req,
    output db_entry_t  ins_entry,
    input  logic       ins_ack,
    input  logic       ins_err,
    output key_t       lookup_key,
    input  logic       lookup_hit,
    input  value_t     lookup_value,
    input  db_status_t status
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_INSERT,
        WR_RESPOND
    } wr_state_t;

    wr_state_t wr_state;
    logic      wr_fire;
    logic      wr_step;
    logic      wr_is_ins;
    logic      wr_bad;
    logic      rd_fire;
    key_t      key_reg;

    // ----------------------------------------------------------------------
    // Write path
    // ----------------------------------------------------------------------
    // Idle state means no response pending and no insert in flight
    assign awready = init_done && (wr_state == WR_IDLE);
    assign wready  = init_done && (wr_state == WR_IDLE);
    assign wr_fire = awvalid && awready && wvalid && wready;
    assign bvalid  = (wr_state == WR_RESPOND);

    // Every write spends two cycles in WR_INSERT, insert or not
    always_ff @(posedge clk) begin
        if (__srst) begin
            wr_state <= WR_IDLE;
            wr_step  <= 1'b0;
            ins_req  <= 1'b0;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (wr_fire) begin
                        wr_state <= WR_INSERT;
                        wr_step  <= 1'b0;
                        ins_req  <= (awaddr == REG_INSERT);
                    end
                end
                WR_INSERT: begin
                    ins_req <= 1'b0;
                    wr_step <= 1'b1;
                    if (wr_step) begin
                        wr_state <= WR_RESPOND;
                    end
                end
                WR_RESPOND: begin
                    if (bready) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // Decode and insert payload
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            wr_is_ins <= (awaddr == REG_INSERT);
            wr_bad    <= (awaddr != REG_INSERT) && (awaddr != REG_KEY);
            ins_entry <= '{key: key_reg, value: wdata[VALUE_WID-1:0]};
        end
    end

    // Stash answer is on ins_ack/ins_err during the second step
    always_ff @(posedge clk) begin
        if ((wr_state == WR_INSERT) && wr_step) begin
            if (wr_bad || (wr_is_ins && ins_ack && ins_err)) begin
                bresp <= RESP_SLVERR;
            end else begin
                bresp <= RESP_OKAY;
            end
        end
    end

    // Latched key, software visible
    always_ff @(posedge clk) begin
        if (__srst) begin
            key_reg <= '0;
        end else if (wr_fire && (awaddr == REG_KEY)) begin
            key_reg <= wdata[KEY_WID-1:0];
        end
    end

    assign lookup_key = key_reg;

    // ----------------------------------------------------------------------
    // Read path
    // ----------------------------------------------------------------------
    assign arready = init_done && !rvalid;
    assign rd_fire = arvalid && arready;

    always_ff @(posedge clk) begin
        if (__srst) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Search result is combinational, sampled at the AR handshake
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            case (araddr)
                REG_LOOKUP: begin
                    rdata <= {lookup_hit, 7'b0, lookup_value};
                    rresp <= RESP_OKAY;
                end
                REG_STATUS: begin
                    rdata <= axil_data_t'(status);
                    rresp <= RESP_OKAY;
                end
                default: begin
                    rdata <= '0;
                    rresp <= RESP_SLVERR;
                end
            endcase
        end
    end

endmodule : db_axil_front

//--- rtl/db_evict.sv
`timescale 1ns/10ps

module db_evict
    import db_pkg::*;
#(
    parameter int EVICT_THRESH = 6
) (
    input  logic       clk,
    input  logic       __srst,
    input  db_status_t status,

    // Pop port to the stash
    output logic       pop_req,
    input  logic       pop_ack,
    input  db_entry_t  pop_entry,

    // Eviction stream
    output logic       evict_valid,
    output db_entry_t  evict_entry,
    input  logic       evict_ready
);

    typedef enum logic [1:0] {
        EV_IDLE,
        EV_POPPING,
        EV_OFFERING
    } ev_state_t;

    ev_state_t state;

    // ----------------------------------------------------------------------
    // Control
    // ----------------------------------------------------------------------
    assign pop_req     = (state == EV_POPPING);
    assign evict_valid = (state == EV_OFFERING);

    always_ff @(posedge clk) begin
        if (__srst) begin
            state <= EV_IDLE;
        end else begin
            case (state)
                EV_IDLE: begin
                    if (status.fill > fill_t'(EVICT_THRESH)) begin
                        state <= EV_POPPING;
                    end
                end
                EV_POPPING: begin
                    if (pop_ack) begin
                        state <= EV_OFFERING;
                    end
                end
                EV_OFFERING: begin
                    if (evict_ready) begin
                        state <= EV_IDLE;
                    end
                end
                default: state <= EV_IDLE;
            endcase
        end
    end

    // Entry in hand, held until the stream takes it
    always_ff @(posedge clk) begin
        if ((state == EV_POPPING) && pop_ack) begin
            evict_entry <= pop_entry;
        end
    end

endmodule : db_evict

//--- rtl/db_stash_top.sv
`timescale 1ns/10ps

module db_stash_top
    import db_pkg::*;
#(
    parameter int SIZE         = 8,
    parameter int EVICT_THRESH = 6
) (
    input  logic       clk,
    input  logic       __srst,

    // AXI4-Lite register port
    input  logic       awvalid,
    output logic       awready,
    input  axil_addr_t awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  axil_data_t wdata,
    output logic       bvalid,
    input  logic       bready,
    output axil_resp_t bresp,
    input  logic       arvalid,
    output logic       arready,
    input  axil_addr_t araddr,
    output logic       rvalid,
    input  logic       rready,
    output axil_data_t rdata,
    output axil_resp_t rresp,

    // Eviction stream
    output logic       evict_valid,
    output db_entry_t  evict_entry,
    input  logic       evict_ready,

    output logic       init_done
);

    // ----------------------------------------------------------------------
    // Internal wiring
    // ----------------------------------------------------------------------
    logic       ins_req;
    db_entry_t  ins_entry;
    logic       ins_ack;
    logic       ins_err;
    logic       pop_req;
    logic       pop_ack;
    db_entry_t  pop_entry;
    key_t       lookup_key;
    logic       lookup_hit;
    value_t     lookup_value;
    db_status_t status;

    db_axil_front i_front (
        .clk          (clk),
        .__srst       (__srst),
        .init_done    (init_done),
        .awvalid      (awvalid),
        .awready      (awready),
        .awaddr       (awaddr),
        .wvalid       (wvalid),
        .wready       (wready),
        .wdata        (wdata),
        .bvalid       (bvalid),
        .bready       (bready),
        .bresp        (bresp),
        .arvalid      (arvalid),
        .arready      (arready),
        .araddr       (araddr),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .rresp        (rresp),
        .ins_req      (ins_req),
        .ins_entry    (ins_entry),
        .ins_ack      (ins_ack),
        .ins_err      (ins_err),
        .lookup_key   (lookup_key),
        .lookup_hit   (lookup_hit),
        .lookup_value (lookup_value),
        .status       (status)
    );

    db_stash_fifo #(
        .SIZE (SIZE)
    ) i_stash (
        .clk          (clk),
        .__srst       (__srst),
        .init_done    (init_done),
        .ins_req      (ins_req),
        .ins_entry    (ins_entry),
        .ins_ack      (ins_ack),
        .ins_err      (ins_err),
        .pop_req      (pop_req),
        .pop_ack      (pop_ack),
        .pop_entry    (pop_entry),
        .lookup_key   (lookup_key),
        .lookup_hit   (lookup_hit),
        .lookup_value (lookup_value),
        .status       (status)
    );

    db_evict #(
        .EVICT_THRESH (EVICT_THRESH)
    ) i_evict (
        .clk          (clk),
        .__srst       (__srst),
        .status       (status),
        .pop_req      (pop_req),
        .pop_ack      (pop_ack),
        .pop_entry    (pop_entry),
        .evict_valid  (evict_valid),
        .evict_entry  (evict_entry),
        .evict_ready  (evict_ready)
    );

endmodule : db_stash_top

//--- sim/db_stash_sva.sv
`timescale 1ns/10ps

module db_stash_sva
    import db_pkg::*;
#(
    parameter int SIZE = 8
) (
    input logic       clk,
    input logic       __srst,
    input logic       ins_req,
    input logic       ins_ack,
    input logic       pop_ack,
    input db_status_t status,
    input logic       evict_valid,
    input logic       evict_ready,
    input db_entry_t  evict_entry
);

    int err_count = 0;

    ins_ack_follows: assert property (@(posedge clk) disable iff (__srst)
        ins_req |=> ins_ack)
        else begin
            err_count++;
            $error("ins_ack missing after ins_req");
        end

    // A pop is never served while an insert is requested
    pop_not_with_insert: assert property (@(posedge clk) disable iff (__srst)
        ins_req |=> !pop_ack)
        else begin
            err_count++;
            $error("pop served during insert");
        end

    fill_in_range: assert property (@(posedge clk) disable iff (__srst)
        status.fill <= fill_t'(SIZE))
        else begin
            err_count++;
            $error("fill above SIZE");
        end

    evict_stable: assert property (@(posedge clk) disable iff (__srst)
        evict_valid && !evict_ready |=> evict_valid && $stable(evict_entry))
        else begin
            err_count++;
            $error("eviction entry changed while stalled");
        end

endmodule : db_stash_sva

bind db_stash_top db_stash_sva #(.SIZE(SIZE)) sva0 (
    .clk         (clk),
    .__srst      (__srst),
    .ins_req     (ins_req),
    .ins_ack     (ins_ack),
    .pop_ack     (pop_ack),
    .status      (status),
    .evict_valid (evict_valid),
    .evict_ready (evict_ready),
    .evict_entry (evict_entry)
);

//--- sim/tb_db_stash.sv
`timescale 1ns/10ps

module tb_db_stash
    import db_pkg::*;
;
    localparam int SIZE         = 8;
    localparam int EVICT_THRESH = 6;
    localparam int TIMEOUT      = 200;

    logic clk, __srst;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    axil_addr_t awaddr, araddr;
    axil_data_t wdata, rdata;
    axil_resp_t bresp, rresp;
    logic evict_valid, evict_ready, init_done;
    db_entry_t evict_entry;

    db_entry_t model_q[$];
    db_entry_t evicted_q[$];
    logic [31:0] rng, ready_rng;
    logic ready_random;
    logic entry_taken;
    axil_data_t rd_data;
    axil_resp_t rsp;

    db_stash_top #(.SIZE(SIZE), .EVICT_THRESH(EVICT_THRESH)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    function automatic axil_data_t expected_lookup(input key_t k);
        for (int i = model_q.size() - 1; i >= 0; i--) begin
            if (model_q[i].key == k) begin
                return {1'b1, 7'b0, model_q[i].value};
            end
        end
        return '0;
    endfunction

    function automatic axil_resp_t expected_resp();
        return (model_q.size() == SIZE) ? RESP_SLVERR : RESP_OKAY;
    endfunction

    // Full in bit 9, empty in bit 8, fill in bits 7:0
    function automatic axil_data_t expected_status();
        int cnt;
        cnt = model_q.size();
        return {22'b0, cnt == SIZE, cnt == 0, fill_t'(cnt)};
    endfunction

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
        if (got !== exp) begin
            $display("ERROR at %0t: %s: got %h expected %h", $time, msg, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string msg);
        $display("Timed out waiting for %s at %0t", msg, $time);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_assertion();
        $display("An assertion on the stash failed before %0t", $time);
        $display("test failed");
        $fatal(1);
    endtask

    // ------------------------------------------------------------------
    // AXI4-Lite access
    // ------------------------------------------------------------------
    task automatic axi_write(input axil_addr_t a, input axil_data_t d, output axil_resp_t r);
        int n;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = a;
        wdata   = d;
        for (n = 0; n < TIMEOUT && !(awready && wready); n++) begin
            @(posedge clk);
            #1;
        end
        if (n == TIMEOUT) report_timeout("write address and data ready");
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        for (n = 0; n < TIMEOUT && !bvalid; n++) begin
            @(posedge clk);
            #1;
        end
        if (n == TIMEOUT) report_timeout("write response");
        r = bresp;
        @(posedge clk);
        #1;
    endtask

    task automatic axi_read(input axil_addr_t a, output axil_data_t d, output axil_resp_t r);
        int n;
        arvalid = 1'b1;
        araddr  = a;
        for (n = 0; n < TIMEOUT && !arready; n++) begin
            @(posedge clk);
            #1;
        end
        if (n == TIMEOUT) report_timeout("read address ready");
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        for (n = 0; n < TIMEOUT && !rvalid; n++) begin
            @(posedge clk);
            #1;
        end
        if (n == TIMEOUT) report_timeout("read data");
        d = rdata;
        r = rresp;
        @(posedge clk);
        #1;
    endtask

    task automatic insert_pair(input key_t k, input value_t v);
        axil_resp_t exp;
        axi_write(REG_KEY, axil_data_t'(k), rsp);
        check(rsp, RESP_OKAY, "key write response");
        exp = expected_resp();
        axi_write(REG_INSERT, axil_data_t'(v), rsp);
        check(rsp, exp, "insert response");
        if (exp == RESP_OKAY) model_q.push_back('{key: k, value: v});
    endtask

    task automatic check_status();
        axi_read(REG_STATUS, rd_data, rsp);
        check(rsp, RESP_OKAY, "status response");
        check(rd_data, expected_status(), "status");
    endtask

    task automatic check_lookup(input key_t k);
        axi_write(REG_KEY, axil_data_t'(k), rsp);
        check(rsp, RESP_OKAY, "key write response");
        axi_read(REG_LOOKUP, rd_data, rsp);
        check(rsp, RESP_OKAY, "lookup response");
        check(rd_data, expected_lookup(k), "lookup data");
    endtask

    // Waits until the evictor has drained the model to the threshold
    task automatic wait_drained();
        int n;
        for (n = 0; n < TIMEOUT && (model_q.size() > EVICT_THRESH || evict_valid); n++) begin
            @(posedge clk);
            #1;
        end
        if (n == TIMEOUT) report_timeout("eviction to drain the stash");
    endtask

    // ------------------------------------------------------------------
    // Eviction monitor and compare
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (__srst) begin
            entry_taken <= 1'b0;
        end else if (evict_valid) begin
            if (!entry_taken) begin
                check(model_q.size() > EVICT_THRESH, 1'b1, "eviction below threshold");
                evicted_q.push_back(model_q.pop_front());
                entry_taken <= 1'b1;
            end
            if (evict_ready) begin
                check(evict_entry, evicted_q.pop_front(), "evicted entry");
                entry_taken <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (dut0.sva0.err_count != 0) begin
            report_assertion();
        end
    end

    always @(posedge clk) begin
        #1;
        ready_rng   = lcg_next(ready_rng);
        evict_ready = ready_random && ready_rng[17];
    end

    initial begin
        key_t first_key;
        key_t k;
        int n;
        rng = 32'h1fc2;
        ready_rng = 32'h1fc2;
        ready_random = 1'b0;
        __srst = 1'b1;
        awvalid = 1'b1;
        wvalid = 1'b1;
        arvalid = 1'b1;
        awaddr = REG_KEY;
        araddr = REG_STATUS;
        wdata = '0;
        bready = 1'b1;
        rready = 1'b1;
        evict_ready = 1'b0;

        // Requests held during reset must see no ready
        repeat (3) begin
            @(posedge clk);
            #1;
            check({awready, wready, arready, init_done}, 4'b0, "ready during reset");
        end
        __srst = 1'b0;

        // Still held in the cycle before init_done
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b0;
        check(init_done, 1'b1, "init_done one cycle after reset");
        repeat (2) begin
            @(posedge clk);
            #1;
            check({bvalid, rvalid}, 2'b0, "response to a request before init_done");
        end
        check_status();

        // Fill to the threshold, one duplicate key
        for (int i = 0; i < EVICT_THRESH; i++) begin
            rng = lcg_next(rng);
            k = (i == 3) ? first_key : key_t'(rng[31:16]);
            if (i == 0) first_key = k;
            rng = lcg_next(rng);
            insert_pair(k, value_t'(rng));
            check_status();
        end
        foreach (model_q[i]) check_lookup(model_q[i].key);
        for (int i = 0; i < 2; i++) begin
            do begin
                rng = lcg_next(rng);
                k = key_t'(rng[31:16]);
            end while (expected_lookup(k) != '0);
            check_lookup(k);
        end

        // Cross the threshold with random back-pressure
        ready_random = 1'b1;
        for (int i = 0; i < 10; i++) begin
            rng = lcg_next(rng);
            insert_pair(key_t'(rng[31:16]), value_t'(rng));
            wait_drained();
        end
        check_status();

        // Stall the stream and fill up
        ready_random = 1'b0;
        while (model_q.size() < SIZE) begin
            rng = lcg_next(rng);
            insert_pair(key_t'(rng[31:16]), value_t'(rng));
            for (n = 0; n < TIMEOUT && model_q.size() > EVICT_THRESH && !evict_valid; n++) begin
                @(posedge clk);
                #1;
            end
            if (n == TIMEOUT) report_timeout("stalled eviction entry");
            check_status();
        end
        rng = lcg_next(rng);
        insert_pair(key_t'(rng[31:16]), value_t'(rng));
        check_status();
        axi_read(8'h40, rd_data, rsp);
        check(rsp, RESP_SLVERR, "unmapped read response");
        check(rd_data, '0, "unmapped read data");

        if (dut0.sva0.err_count != 0) begin
            report_assertion();
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule : tb_db_stash

//--- src.f
common/db_pkg.sv
db_stash/db_stash_fifo.sv
rtl/db_axil_front.sv
rtl/db_evict.sv
rtl/db_stash_top.sv
sim/db_stash_sva.sv
sim/tb_db_stash.sv

//--- Bender.yml
package:
  name: db_stash

sources:
  - common/db_pkg.sv
  - db_stash/db_stash_fifo.sv
  - rtl/db_axil_front.sv
  - rtl/db_evict.sv
  - rtl/db_stash_top.sv
  - target: test
    files:
      - sim/db_stash_sva.sv
      - sim/tb_db_stash.sv
